/* verilog/viterbi_defines.svh */
`ifndef VITERBI_DEFINES_SVH
`define VITERBI_DEFINES_SVH

// ----------------------------------------------------------------------
// convolutional code, rate 1/2
// ----------------------------------------------------------------------
`define VIT_K           4        // constraint length
`define VIT_STATES      8        // 2**(K-1) trellis states

// tap masks, new input bit in the MSB
`define VIT_G0          4'b1011  // 13 octal, symbol bit 1
`define VIT_G1          4'b1111  // 17 octal, symbol bit 0

// ----------------------------------------------------------------------
// frame and metric sizing
// ----------------------------------------------------------------------
`define VIT_FRAME_LEN   256      // symbols per frame, tail included
`define VIT_ADDR_W      8        // index into one frame

// kept narrow so normalization happens often
`define VIT_PM_W        5

`endif

/* verilog/viterbi_pkg.sv */
package viterbi_pkg;

`include "viterbi_defines.svh"

   // one received code symbol, {g0 bit, g1 bit}
   typedef logic [1:0] sym_t;

   // trellis state, newest input bit in the MSB
   typedef logic [`VIT_K-2:0] state_t;

   // accumulated Hamming cost of a survivor path
   typedef logic [`VIT_PM_W-1:0] metric_t;

   // one decision bit per state for a trellis step
   // bit set means the predecessor ending in 1 won
   typedef logic [`VIT_STATES-1:0] decision_t;

   // symbol index within a frame
   typedef logic [`VIT_ADDR_W-1:0] frame_addr_t;

endpackage

/* verilog/ram_if.sv */
`timescale 1ns/1ps

interface ram_if #(
   parameter type data_t = logic,
   parameter int  DEPTH  = 256
) ();

   localparam int ADDR_W = $clog2(DEPTH);

   logic              we;
   logic [ADDR_W-1:0] waddr;
   data_t             wdata;
   logic [ADDR_W-1:0] raddr;
   data_t             rdata;    // belongs to last cycle's raddr

   modport writer (output we, output waddr, output wdata);

   modport reader (output raddr, input rdata);

   modport mem (
      input  we,
      input  waddr,
      input  wdata,
      input  raddr,
      output rdata
   );

endinterface

/* verilog/sdp_ram.sv */
`timescale 1ns/1ps

module sdp_ram #(
   parameter type data_t = logic,
   parameter int  DEPTH  = 256
) (
   input logic clk,
   ram_if.mem  mem_if
);

   data_t mem [DEPTH];

   // write port
   always_ff @(posedge clk) begin
      if (mem_if.we) begin
         mem[mem_if.waddr] <= mem_if.wdata;
      end
   end

   // read port, one cycle latency
   // a read of the address being written returns the old word
   always_ff @(posedge clk) begin
      mem_if.rdata <= mem[mem_if.raddr];
   end

endmodule

/* verilog/path_metric_unit.sv */
`timescale 1ns/1ps
`include "viterbi_defines.svh"

module path_metric_unit (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   advance_i,
   input  logic                   clear_i,
   input  viterbi_pkg::sym_t      sym_i,
   output viterbi_pkg::decision_t decision_o
);

   viterbi_pkg::metric_t   pm_q [`VIT_STATES];
   viterbi_pkg::metric_t   pm_d [`VIT_STATES];
   logic [`VIT_STATES-1:0] valid_q;
   logic [`VIT_STATES-1:0] valid_d;
   logic [`VIT_STATES-1:0] msb_set;  // MSB set or state not in use
   logic [1:0]             bm [4];   // distance to each codeword
   logic                   norm;

   // codeword on the branch into s from predecessor {s[1:0], low}
   function automatic viterbi_pkg::sym_t branch_sym(input viterbi_pkg::state_t s,
                                                    input logic low);
      logic [`VIT_K-1:0] taps;
      taps = {s[2], s[1:0], low};
      return {^(taps & `VIT_G0), ^(taps & `VIT_G1)};
   endfunction

   // ----------------------------------------------------------------------
   // branch metrics
   // ----------------------------------------------------------------------
   always_comb begin : bmc
      logic [1:0] diff;
      for (int c = 0; c < 4; c++) begin
         diff  = sym_i ^ 2'(c);
         bm[c] = {1'b0, diff[1]} + {1'b0, diff[0]};
      end
   end

   // ----------------------------------------------------------------------
   // add compare select, one per state
   // ----------------------------------------------------------------------
   always_comb begin : acs
      viterbi_pkg::state_t  st;
      viterbi_pkg::state_t  p0;
      viterbi_pkg::state_t  p1;
      viterbi_pkg::metric_t m0;
      viterbi_pkg::metric_t m1;
      for (int s = 0; s < `VIT_STATES; s++) begin
         st = viterbi_pkg::state_t'(s);
         p0 = {st[1:0], 1'b0};
         p1 = {st[1:0], 1'b1};
         m0 = pm_q[p0] + viterbi_pkg::metric_t'(bm[branch_sym(st, 1'b0)]);
         m1 = pm_q[p1] + viterbi_pkg::metric_t'(bm[branch_sym(st, 1'b1)]);
         if (valid_q[p1] && (!valid_q[p0] || (m1 < m0))) begin
            decision_o[s] = 1'b1;
            pm_d[s]       = m1;
         end else begin
            decision_o[s] = 1'b0;   // ties go to the low predecessor
            pm_d[s]       = m0;
         end
         valid_d[s] = valid_q[p0] | valid_q[p1];
         msb_set[s] = pm_d[s][`VIT_PM_W-1] | ~valid_d[s];
      end
   end

   assign norm = &msb_set;   // every live metric past half range

   // ----------------------------------------------------------------------
   // metric and validity registers
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         valid_q <= {{(`VIT_STATES-1){1'b0}}, 1'b1};
         for (int s = 0; s < `VIT_STATES; s++) begin
            pm_q[s] <= '0;
         end
      end else if (clear_i) begin
         valid_q <= {{(`VIT_STATES-1){1'b0}}, 1'b1};   // only state 0 at frame start
         for (int s = 0; s < `VIT_STATES; s++) begin
            pm_q[s] <= '0;
         end
      end else if (advance_i) begin
         valid_q <= valid_d;
         for (int s = 0; s < `VIT_STATES; s++) begin
            pm_q[s] <= norm ? {1'b0, pm_d[s][`VIT_PM_W-2:0]} : pm_d[s];
         end
      end
   end

endmodule

/* verilog/traceback_unit.sv */
`timescale 1ns/1ps
`include "viterbi_defines.svh"

module traceback_unit (
   input  logic  clk,
   input  logic  rst,
   input  logic  start_i,
   ram_if.reader surv_rd,
   ram_if.writer order_wr,
   output logic  done_o
);

   viterbi_pkg::frame_addr_t rd_idx;      // next survivor word to fetch
   viterbi_pkg::frame_addr_t rsp_idx;     // index of the word now on rdata
   logic                     rd_active;
   logic                     rsp_valid;
   viterbi_pkg::state_t      cur_state;

   // ----------------------------------------------------------------------
   // read side, last symbol first
   // ----------------------------------------------------------------------
   assign surv_rd.raddr = rd_idx;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         rd_active <= 1'b0;
         rd_idx    <= '0;
      end else if (start_i) begin
         rd_active <= 1'b1;
         rd_idx    <= viterbi_pkg::frame_addr_t'(`VIT_FRAME_LEN - 1);
      end else if (rd_active) begin
         rd_idx <= rd_idx - 1'b1;
         if (rd_idx == '0) begin
            rd_active <= 1'b0;   // index 0 issued
         end
      end
   end

   // ----------------------------------------------------------------------
   // walk back one step per returned word
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         rsp_valid <= 1'b0;
         rsp_idx   <= '0;
         cur_state <= '0;
         done_o    <= 1'b0;
      end else begin
         rsp_valid <= rd_active;
         rsp_idx   <= rd_idx;
         done_o    <= rsp_valid && (rsp_idx == '0);
         if (start_i) begin
            cur_state <= '0;   // tail bits flush the encoder to 0
         end else if (rsp_valid) begin
            cur_state <= {cur_state[1:0], surv_rd.rdata[cur_state]};
         end
      end
   end

   // decoded bit lands at its own index, so the frame reads out in order
   assign order_wr.we    = rsp_valid;
   assign order_wr.waddr = rsp_idx;
   assign order_wr.wdata = cur_state[2];

endmodule

/* verilog/frame_control.sv */
`timescale 1ns/1ps
`include "viterbi_defines.svh"

module frame_control (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   sym_valid_i,
   output logic                   sym_ready_o,
   input  viterbi_pkg::decision_t decision_i,
   output logic                   advance_o,
   output logic                   clear_o,
   ram_if.writer                  surv_wr,
   output logic                   tb_start_o,
   input  logic                   tb_done_i,
   ram_if.reader                  order_rd,
   output logic                   bit_valid_o,
   output logic                   bit_o
);

   typedef enum logic [1:0] {
      PH_ACCEPT,   // taking symbols
      PH_TRACE,    // traceback running
      PH_EMIT      // reading out decoded bits
   } phase_t;

   phase_t                   phase;
   viterbi_pkg::frame_addr_t idx;          // symbol index, then output index
   logic                     xfer;
   logic                     last_sym;
   logic                     emit_rd;
   logic                     emit_drain;

   // ----------------------------------------------------------------------
   // input side
   // ----------------------------------------------------------------------
   assign sym_ready_o = (phase == PH_ACCEPT);
   assign xfer        = sym_valid_i & sym_ready_o;
   assign last_sym    = (idx == viterbi_pkg::frame_addr_t'(`VIT_FRAME_LEN - 1));

   assign advance_o = xfer;
   assign clear_o   = (phase != PH_ACCEPT);   // metrics restart for the next frame

   // decisions stored on the same edge the metrics move
   assign surv_wr.we    = xfer;
   assign surv_wr.waddr = idx;
   assign surv_wr.wdata = decision_i;

   // ----------------------------------------------------------------------
   // output side
   // ----------------------------------------------------------------------
   // idx has wrapped to 0 and the last beat is on the output
   assign emit_drain = (phase == PH_EMIT) && bit_valid_o && (idx == '0);
   assign emit_rd    = (phase == PH_EMIT) && !emit_drain;

   assign order_rd.raddr = idx;
   assign bit_o          = order_rd.rdata;

   // ----------------------------------------------------------------------
   // frame FSM
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         phase       <= PH_ACCEPT;
         idx         <= '0;
         tb_start_o  <= 1'b0;
         bit_valid_o <= 1'b0;
      end else begin
         tb_start_o  <= xfer && last_sym;   // one cycle pulse
         bit_valid_o <= emit_rd;            // data follows the read
         case (phase)
            PH_ACCEPT: begin
               if (xfer) begin
                  idx <= idx + 1'b1;        // wraps to 0 after the last symbol
                  if (last_sym) begin
                     phase <= PH_TRACE;
                  end
               end
            end
            PH_TRACE: begin
               if (tb_done_i) begin
                  phase <= PH_EMIT;
               end
            end
            PH_EMIT: begin
               if (emit_drain) begin
                  phase <= PH_ACCEPT;       // ready again after the last beat
               end else begin
                  idx <= idx + 1'b1;
               end
            end
            default: begin
               phase <= PH_ACCEPT;
            end
         endcase
      end
   end

endmodule

/* verilog/viterbi_decoder.sv */
`timescale 1ns/1ps
`include "viterbi_defines.svh"

module viterbi_decoder (
   input  logic              clk,
   input  logic              rst,
   input  logic              sym_valid_i,
   input  viterbi_pkg::sym_t sym_i,
   output logic              sym_ready_o,
   output logic              bit_valid_o,
   output logic              bit_o
);

   viterbi_pkg::decision_t decision;
   logic                   advance;
   logic                   clear;
   logic                   tb_start;
   logic                   tb_done;

   // ----------------------------------------------------------------------
   // memory buses
   // ----------------------------------------------------------------------
   ram_if #(.data_t(viterbi_pkg::decision_t), .DEPTH(`VIT_FRAME_LEN)) surv_bus ();
   ram_if #(.data_t(logic), .DEPTH(`VIT_FRAME_LEN)) order_bus ();   // bit reorder

   // ----------------------------------------------------------------------
   // datapath and control
   // ----------------------------------------------------------------------
   path_metric_unit u_path_metric_unit (
      .clk        (clk),
      .rst        (rst),
      .advance_i  (advance),
      .clear_i    (clear),
      .sym_i      (sym_i),
      .decision_o (decision)
   );

   frame_control u_frame_control (
      .clk         (clk),
      .rst         (rst),
      .sym_valid_i (sym_valid_i),
      .sym_ready_o (sym_ready_o),
      .decision_i  (decision),
      .advance_o   (advance),
      .clear_o     (clear),
      .surv_wr     (surv_bus.writer),
      .tb_start_o  (tb_start),
      .tb_done_i   (tb_done),
      .order_rd    (order_bus.reader),
      .bit_valid_o (bit_valid_o),
      .bit_o       (bit_o)
   );

   traceback_unit u_traceback_unit (
      .clk      (clk),
      .rst      (rst),
      .start_i  (tb_start),
      .surv_rd  (surv_bus.reader),
      .order_wr (order_bus.writer),
      .done_o   (tb_done)
   );

   sdp_ram #(.data_t(viterbi_pkg::decision_t), .DEPTH(`VIT_FRAME_LEN)) u_surv_ram (
      .clk    (clk),
      .mem_if (surv_bus.mem)
   );

   sdp_ram #(.data_t(logic), .DEPTH(`VIT_FRAME_LEN)) u_order_ram (
      .clk    (clk),
      .mem_if (order_bus.mem)
   );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS  = 4,
   parameter int RST_CYCLES = 10
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk_o = ~clk_o;
      end
   end

   // active low, released between edges
   initial begin
      rst_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b1;
   end

endmodule

/* verif/viterbi_assertions.sv */
`timescale 1ns/1ps

module viterbi_assertions (
   input logic clk,
   input logic rst,
   input logic sym_ready_i,
   input logic bit_valid_i,
   input logic bit_i
);

   // output burst only starts once input is closed
   burst_starts_with_ready_low: assert property (
      @(posedge clk) disable iff (!rst)
      $rose(bit_valid_i) |-> !sym_ready_i
   ) else $error("bit_valid_o rose while sym_ready_o was high");

   // every beat carries a real value
   beat_is_known: assert property (
      @(posedge clk) disable iff (!rst)
      bit_valid_i |-> !$isunknown(bit_i)
   ) else $error("bit_o unknown during an output beat");

   ready_after_reset: assert property (
      @(posedge clk) $rose(rst) |-> sym_ready_i
   ) else $error("sym_ready_o low in the first cycle after reset");

endmodule

bind viterbi_decoder viterbi_assertions u_viterbi_assertions (
   .clk         (clk),
   .rst         (rst),
   .sym_ready_i (sym_ready_o),
   .bit_valid_i (bit_valid_o),
   .bit_i       (bit_o)
);

/* verif/viterbi_tb.sv */
`timescale 1ns/1ps
`include "viterbi_defines.svh"

module viterbi_tb;

   localparam int CLK_PERIOD = 4;
   localparam int N_FRAMES   = 23;    // three directed frames and twenty back to back
   localparam int LEN        = `VIT_FRAME_LEN;

   logic              clk;
   logic              rst;
   logic              sym_valid;
   viterbi_pkg::sym_t sym_data;
   logic              sym_ready;
   logic              bit_valid;
   logic              bit_data;

   integer            seed = 32'h664f_393e;
   logic              exp_q [$];            // decoded bits still owed by the DUT
   logic              data_bits [LEN];
   viterbi_pkg::sym_t syms [LEN];
   int                beats_seen = 0;
   int                frames_sent = 0;

   tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(10)) u_tb_clock_gen (
      .clk_o (clk),
      .rst_o (rst)
   );

   viterbi_decoder u_viterbi_decoder (
      .clk         (clk),
      .rst         (rst),
      .sym_valid_i (sym_valid),
      .sym_i       (sym_data),
      .sym_ready_o (sym_ready),
      .bit_valid_o (bit_valid),
      .bit_o       (bit_data)
   );

   // ----------------------------------------------------------------------
   // error reporting and compare tasks
   // ----------------------------------------------------------------------
   task automatic report_fail(input string what);
      $display("%s", what);
      $display(">>> FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_bit(input logic got, input logic exp);
      if (got !== exp) begin
         report_fail($sformatf("MISMATCH at %0t: frame %0d bit %0d is %b, expected %b",
                               $time, beats_seen / LEN, beats_seen % LEN, got, exp));
      end
   endtask

   task automatic check_ready(input logic exp_ready, input logic exp_valid);
      if (sym_ready !== exp_ready || bit_valid !== exp_valid) begin
         report_fail($sformatf("MISMATCH at %0t: ready/valid %b/%b, expected %b/%b",
                               $time, sym_ready, bit_valid, exp_ready, exp_valid));
      end
   endtask

   task automatic check_count(input int got, input int exp);
      if (got != exp) begin
         report_fail($sformatf("MISMATCH at %0t: %0d output beats, expected %0d",
                               $time, got, exp));
      end
   endtask

   // ----------------------------------------------------------------------
   // random frame data with a zero tail, encoded at rate 1/2
   // ----------------------------------------------------------------------
   task automatic build_frame(input bit noisy);
      viterbi_pkg::state_t enc;
      logic [`VIT_K-1:0]   taps;
      int                  pos;
      int                  sel;
      enc = '0;
      for (int i = 0; i < LEN; i++) begin
         if (i < LEN - (`VIT_K - 1)) begin
            data_bits[i] = 1'($random(seed));
         end else begin
            data_bits[i] = 1'b0;          // flush back to state 0
         end
         taps    = {data_bits[i], enc};
         syms[i] = {^(taps & `VIT_G0), ^(taps & `VIT_G1)};
         enc     = {data_bits[i], enc[2:1]};
         exp_q.push_back(data_bits[i]);
      end
      if (noisy) begin
         // one flipped symbol bit per aligned window of 16
         for (int w = 0; w < LEN / 16; w++) begin
            pos = w * 16 + ($random(seed) & 15);
            sel = $random(seed) & 1;
            syms[pos][sel] = ~syms[pos][sel];
         end
      end
   endtask

   task automatic run_frame(input bit noisy, input bit idles);
      int idx;
      build_frame(noisy);
      frames_sent++;
      idx = 0;
      while (idx < LEN) begin
         @(negedge clk);
         if (idles && (($random(seed) & 3) == 0)) begin
            sym_valid = 1'b0;
         end else begin
            sym_valid = 1'b1;
            sym_data  = syms[idx];
         end
         if (sym_valid && sym_ready) begin
            idx++;                        // transfers on the coming edge
         end
      end
      @(negedge clk);
      check_ready(1'b0, 1'b0);            // frame closed and input held off
   endtask

   task automatic finish_output();
      sym_valid = 1'b0;
      @(negedge clk);
      while (sym_ready !== 1'b1) begin
         @(negedge clk);                  // input reopens after the last beat
      end
      check_ready(1'b1, 1'b0);
      check_count(beats_seen, frames_sent * LEN);
   endtask

   // ----------------------------------------------------------------------
   // scoreboard, watchdog and test sequence
   // ----------------------------------------------------------------------
   always @(negedge clk) begin : monitor
      if (rst && bit_valid) begin
         if (exp_q.size() == 0) begin
            report_fail("decoder sent an output beat when no bit was expected");
         end else begin
            check_bit(bit_data, exp_q.pop_front());
            beats_seen++;
         end
      end
   end

   initial begin : watchdog
      #(N_FRAMES * 2000 * CLK_PERIOD);
      report_fail($sformatf("timeout: run did not finish within %0d ns",
                            N_FRAMES * 2000 * CLK_PERIOD));
   end

   initial begin : stimulus
      sym_valid = 1'b0;
      sym_data  = '0;
      wait (rst === 1'b1);
      @(negedge clk);
      check_ready(1'b1, 1'b0);

      run_frame(1'b0, 1'b0);              // clean
      finish_output();
      run_frame(1'b1, 1'b0);              // noisy frame forces normalization
      finish_output();
      run_frame(1'b1, 1'b1);              // random gaps in valid
      finish_output();

      // back to back frames with valid up while the decoder is busy
      for (int f = 0; f < 20; f++) begin
         run_frame(f[0], 1'b0);
      end
      finish_output();

      $display(">>> PASS");
      $finish;
   end

endmodule

/* build.f */
+incdir+verilog
verilog/viterbi_pkg.sv
verilog/ram_if.sv
verilog/sdp_ram.sv
verilog/path_metric_unit.sv
verilog/traceback_unit.sv
verilog/frame_control.sv
verilog/viterbi_decoder.sv
verif/tb_clock_gen.sv
verif/viterbi_assertions.sv
verif/viterbi_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the Viterbi decoder testbench with Verilator.
# The exit status is 0 only when the log holds the pass line.

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
   --top-module viterbi_tb --Mdir "$OBJ_DIR" -o viterbi_sim -f build.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$OBJ_DIR/viterbi_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx '>>> PASS' "$LOG"; then
   exit 0
fi
echo "pass line not found in $LOG"
exit 1
